// ==== fix_defs.svh ====
/*
 * FIX field extraction constants
 * delimiter codes, word geometry and buffer sizing
 */

`ifndef FIX_DEFS_SVH
`define FIX_DEFS_SVH

// SOH ends a field, '=' splits tag from value
`define FIX_SOH 8'h01
`define FIX_SEP 8'h3D

// bytes per stream word, lane 0 first on the wire
`define FIX_LANES 4

`define FIX_FIFO_DEPTH 4

// value bytes kept per field, the rest are dropped and flagged
`define FIX_MAX_VAL_BYTES 8

`endif

// ==== fix_pkg.sv ====
/*
 * FIX field extraction types
 * stream word, lane masks, classified word and field payloads
 */

`include "fix_defs.svh"

package fix_pkg;

	typedef logic [`FIX_LANES*8-1:0] word_t;

	// one bit per byte lane
	typedef logic [`FIX_LANES-1:0] lane_mask_t;

	// data word plus lane classes, exactly one class bit set per lane
	typedef struct packed {
		word_t      data;
		lane_mask_t tag;
		lane_mask_t val;
		lane_mask_t sep;
		lane_mask_t soh;
	} class_word_t;

	typedef logic [15:0] tag_t;

	// first value byte sits in the low byte
	typedef logic [`FIX_MAX_VAL_BYTES*8-1:0] value_t;

	typedef logic [3:0] vlen_t;

endpackage

// ==== fix_lane_classifier.sv ====
/*
 * FIX lane classifier
 * marks each byte lane as tag, value, separator or SOH and registers the word
 */

`timescale 1ns/10ps
`include "fix_defs.svh"

module fix_lane_classifier (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  logic                 in_valid_i,
	output logic                 in_ready_o,
	input  fix_pkg::word_t       in_data_i,
	output logic                 cls_valid_o,
	input  logic                 cls_ready_i,
	output fix_pkg::class_word_t cls_word_o
);

	// mode carried between words, high while inside a value
	logic                 value_mode_q;
	logic                 lane_mode;
	logic [7:0]           lane_byte;
	logic                 accept;
	fix_pkg::class_word_t cls_next;

	// walk lanes in wire order, mode ripples from lane 0 to lane 3
	always_comb begin
		cls_next.data = in_data_i;
		cls_next.tag  = '0;
		cls_next.val  = '0;
		cls_next.sep  = '0;
		cls_next.soh  = '0;
		lane_mode     = value_mode_q;
		lane_byte     = '0;
		for (int i = 0; i < `FIX_LANES; i++) begin
			lane_byte = in_data_i[8*i +: 8];
			if (lane_byte == `FIX_SOH) begin
				cls_next.soh[i] = 1'b1;
				lane_mode       = 1'b0;
			end else if (lane_byte == `FIX_SEP && !lane_mode) begin
				cls_next.sep[i] = 1'b1;
				lane_mode       = 1'b1;
			end else if (lane_mode) begin
				// '=' inside a value is plain data
				cls_next.val[i] = 1'b1;
			end else begin
				cls_next.tag[i] = 1'b1;
			end
		end
	end

	// output register empty or draining, so full rate
	assign in_ready_o = !cls_valid_o || cls_ready_i;
	assign accept     = in_valid_i && in_ready_o;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cls_valid_o  <= 1'b0;
			value_mode_q <= 1'b0;
		end else if (accept) begin
			cls_valid_o  <= 1'b1;
			value_mode_q <= lane_mode;
		end else if (cls_ready_i) begin
			cls_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			cls_word_o <= cls_next;
		end
	end

	// every lane of an offered word belongs to exactly one class
	property p_lane_onehot;
		@(posedge clk_i) disable iff (!arst_n_i)
		cls_valid_o |->
			((cls_word_o.tag | cls_word_o.val | cls_word_o.sep | cls_word_o.soh) == '1) &&
			(((cls_word_o.tag & (cls_word_o.val | cls_word_o.sep | cls_word_o.soh)) |
			  (cls_word_o.val & (cls_word_o.sep | cls_word_o.soh)) |
			  (cls_word_o.sep & cls_word_o.soh)) == '0);
	endproperty
	a_lane_onehot: assert property (p_lane_onehot);

endmodule

// ==== fix_word_fifo.sv ====
/*
 * word FIFO
 * circular buffer with valid/ready on both sides, payload set by type parameter
 */

`timescale 1ns/10ps

module fix_word_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int  DEPTH     = 4
) (
	input  logic     clk_i,
	input  logic     arst_n_i,
	input  logic     wr_valid_i,
	output logic     wr_ready_o,
	input  payload_t wr_data_i,
	output logic     rd_valid_o,
	input  logic     rd_ready_i,
	output payload_t rd_data_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t           mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [PTR_W:0]     count;
	logic               do_wr;
	logic               do_rd;

	// a pop frees its slot in the same cycle, so a full buffer still takes a word
	assign wr_ready_o = (count != (PTR_W+1)'(DEPTH)) || rd_ready_i;
	assign rd_valid_o = (count != '0);
	assign rd_data_o  = mem[rd_ptr];

	assign do_wr = wr_valid_i && wr_ready_o;
	assign do_rd = rd_valid_o && rd_ready_i;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			end
			// simultaneous push and pop leaves the count alone
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data_i;
		end
	end

	// a full buffer only leaves the full state through a pop
	a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(count == (PTR_W+1)'(DEPTH)) && !do_rd |=> count == (PTR_W+1)'(DEPTH));

	// an empty buffer only leaves the empty state through a push
	a_no_underflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(count == '0) && !do_wr |=> count == '0);

endmodule

// ==== fix_field_assembler.sv ====
/*
 * FIX field assembler
 * walks classified lanes one per cycle, builds tag number and value bytes per field
 */

`timescale 1ns/10ps
`include "fix_defs.svh"

module fix_field_assembler (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  logic                 buf_valid_i,
	output logic                 buf_ready_o,
	input  fix_pkg::class_word_t buf_word_i,
	output logic                 field_valid_o,
	input  logic                 field_ready_i,
	output fix_pkg::tag_t        field_tag_o,
	output fix_pkg::value_t      field_value_o,
	output fix_pkg::vlen_t       field_len_o,
	output logic                 field_trunc_o,
	output logic                 field_err_o
);

	localparam int LANE_W = $clog2(`FIX_LANES);

	logic [LANE_W-1:0] lane_idx;
	logic [7:0]        cur_byte;
	logic              is_tag;
	logic              is_val;
	logic              is_soh;
	logic              is_digit;
	logic              step;
	logic              load;

	fix_pkg::tag_t     tag_acc;
	fix_pkg::value_t   val_acc;
	fix_pkg::vlen_t    len_acc;
	logic              has_digit;
	logic              err_acc;
	logic              trunc_acc;

	assign cur_byte = buf_word_i.data[8*lane_idx +: 8];
	assign is_tag   = buf_word_i.tag[lane_idx];
	assign is_val   = buf_word_i.val[lane_idx];
	assign is_soh   = buf_word_i.soh[lane_idx];
	assign is_digit = (cur_byte[7:4] == 4'h3) && (cur_byte[3:0] <= 4'd9);

	// SOH loads the field, then parks until the field is taken
	assign load = buf_valid_i && is_soh && !field_valid_o;
	assign step = buf_valid_i && (!is_soh || (field_valid_o && field_ready_i));

	// pop after the last lane of the word moves on
	assign buf_ready_o = step && (lane_idx == LANE_W'(`FIX_LANES-1));

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			lane_idx      <= '0;
			field_valid_o <= 1'b0;
			tag_acc       <= '0;
			val_acc       <= '0;
			len_acc       <= '0;
			has_digit     <= 1'b0;
			err_acc       <= 1'b0;
			trunc_acc     <= 1'b0;
		end else begin
			if (step) begin
				lane_idx <= lane_idx + 1'b1;
			end
			if (load) begin
				field_valid_o <= 1'b1;
				tag_acc       <= '0;
				val_acc       <= '0;
				len_acc       <= '0;
				has_digit     <= 1'b0;
				err_acc       <= 1'b0;
				trunc_acc     <= 1'b0;
			end else if (field_valid_o && field_ready_i) begin
				field_valid_o <= 1'b0;
			end
			if (buf_valid_i && is_tag) begin
				if (is_digit) begin
					// times ten as shift and add
					tag_acc   <= (tag_acc << 3) + (tag_acc << 1) + {12'd0, cur_byte[3:0]};
					has_digit <= 1'b1;
				end else begin
					err_acc <= 1'b1;
				end
			end
			if (buf_valid_i && is_val) begin
				if (len_acc < fix_pkg::vlen_t'(`FIX_MAX_VAL_BYTES)) begin
					val_acc[8*len_acc +: 8] <= cur_byte;
					len_acc                 <= len_acc + 1'b1;
				end else begin
					trunc_acc <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (load) begin
			field_tag_o   <= tag_acc;
			field_value_o <= val_acc;
			field_len_o   <= len_acc;
			field_trunc_o <= trunc_acc;
			// an empty tag counts as malformed too
			field_err_o   <= err_acc || !has_digit;
		end
	end

	// held field stays put until the sink takes it
	a_field_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		field_valid_o && !field_ready_i |=> field_valid_o &&
		$stable({field_tag_o, field_value_o, field_len_o, field_trunc_o, field_err_o}));

endmodule

// ==== fix_field_extract.sv ====
/*
 * FIX field extraction front end
 * lane classifier, word FIFO and field assembler in a chain
 */

`timescale 1ns/10ps
`include "fix_defs.svh"

module fix_field_extract (
	input  logic            clk_i,
	input  logic            arst_n_i,
	input  logic            in_valid_i,
	output logic            in_ready_o,
	input  fix_pkg::word_t  in_data_i,
	output logic            field_valid_o,
	input  logic            field_ready_i,
	output fix_pkg::tag_t   field_tag_o,
	output fix_pkg::value_t field_value_o,
	output fix_pkg::vlen_t  field_len_o,
	output logic            field_trunc_o,
	output logic            field_err_o
);

	logic                 cls_valid;
	logic                 cls_ready;
	fix_pkg::class_word_t cls_word;
	logic                 buf_valid;
	logic                 buf_ready;
	fix_pkg::class_word_t buf_word;

	fix_lane_classifier u_classifier (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.in_valid_i  (in_valid_i),
		.in_ready_o  (in_ready_o),
		.in_data_i   (in_data_i),
		.cls_valid_o (cls_valid),
		.cls_ready_i (cls_ready),
		.cls_word_o  (cls_word)
	);

	// decouples classifier rate from the lane-serial assembler
	fix_word_fifo #(
		.payload_t (fix_pkg::class_word_t),
		.DEPTH     (`FIX_FIFO_DEPTH)
	) u_fifo (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.wr_valid_i (cls_valid),
		.wr_ready_o (cls_ready),
		.wr_data_i  (cls_word),
		.rd_valid_o (buf_valid),
		.rd_ready_i (buf_ready),
		.rd_data_o  (buf_word)
	);

	fix_field_assembler u_assembler (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.buf_valid_i   (buf_valid),
		.buf_ready_o   (buf_ready),
		.buf_word_i    (buf_word),
		.field_valid_o (field_valid_o),
		.field_ready_i (field_ready_i),
		.field_tag_o   (field_tag_o),
		.field_value_o (field_value_o),
		.field_len_o   (field_len_o),
		.field_trunc_o (field_trunc_o),
		.field_err_o   (field_err_o)
	);

endmodule

// ==== tb_fix_field_extract.sv ====
/*
 * testbench for the FIX field extraction front end
 * streams FIX text, predicts fields with a byte-level model, checks by assertion
 */

`timescale 1ns/10ps
`include "fix_defs.svh"

module tb_fix_field_extract;

	localparam int WAIT_LIMIT = 400;
	localparam int FIELD_W    = 16 + 8*`FIX_MAX_VAL_BYTES + 4 + 2;

	logic            clk_i;
	logic            arst_n_i;
	logic            in_valid_i;
	logic            in_ready_o;
	fix_pkg::word_t  in_data_i;
	logic            field_valid_o;
	logic            field_ready_i;
	fix_pkg::tag_t   field_tag_o;
	fix_pkg::value_t field_value_o;
	fix_pkg::vlen_t  field_len_o;
	logic            field_trunc_o;
	logic            field_err_o;

	// expected fields in order, model writes, accepted DUT fields consume
	logic [FIELD_W-1:0] exp_mem [256];
	logic [7:0]         exp_wr;
	logic [7:0]         exp_rd;
	logic [FIELD_W-1:0] exp_head;
	logic [FIELD_W-1:0] act_bits;

	// reference parser state
	logic            m_value_mode;
	fix_pkg::tag_t   m_tag;
	fix_pkg::value_t m_val;
	int              m_len;
	logic            m_digit;
	logic            m_err;
	logic            m_trunc;

	logic [7:0] stream_q [$];
	string      test_name;
	int         error_count;
	logic       rand_mode;
	// words taken by the DUT, counted at the clock edge
	int         words_in;
	logic       timed_out;

	fix_field_extract u_dut (.*);

	assign exp_head = exp_mem[exp_rd];
	assign act_bits = {field_tag_o, field_value_o, field_len_o, field_trunc_o, field_err_o};

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	// sink side, stalls only during the random test
	initial begin
		field_ready_i = 1'b1;
		@(posedge arst_n_i);
		forever begin
			@(negedge clk_i);
			field_ready_i = rand_mode ? ($urandom_range(0, 2) != 0) : 1'b1;
		end
	end

	always @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			exp_rd <= '0;
		end else if (field_valid_o && field_ready_i) begin
			exp_rd <= exp_rd + 1'b1;
		end
	end

	always @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			words_in <= 0;
		end else if (in_valid_i && in_ready_o) begin
			words_in <= words_in + 1;
		end
	end

	a_field_match: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		field_valid_o && field_ready_i |-> act_bits == exp_head)
	else begin
		$display("ERR %s: expected %h, actual %h", test_name, $sampled(exp_head),
			$sampled(act_bits));
		error_count++;
	end

	a_field_predicted: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		field_valid_o && field_ready_i |-> exp_rd != exp_wr)
	else begin
		$display("test %s: DUT emitted a field that the model did not predict", test_name);
		error_count++;
	end

	a_field_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		field_valid_o && !field_ready_i |=> field_valid_o && $stable(act_bits))
	else begin
		$display("test %s: field outputs changed while the sink was stalling", test_name);
		error_count++;
	end

	task automatic report_timeout(input string what);
		error_count++;
		timed_out = 1'b1;
		$display("timeout in test %s while waiting for %s", test_name, what);
	endtask

	// one byte through the classification and assembly rules
	task automatic model_byte(input logic [7:0] b);
		if (b == `FIX_SOH) begin
			exp_mem[exp_wr] = {m_tag, m_val, 4'(m_len), m_trunc, m_err || !m_digit};
			exp_wr       = exp_wr + 1'b1;
			m_value_mode = 1'b0;
			m_tag        = '0;
			m_val        = '0;
			m_len        = 0;
			m_digit      = 1'b0;
			m_err        = 1'b0;
			m_trunc      = 1'b0;
		end else if (!m_value_mode && b == `FIX_SEP) begin
			m_value_mode = 1'b1;
		end else if (m_value_mode) begin
			if (m_len < `FIX_MAX_VAL_BYTES) begin
				m_val[8*m_len +: 8] = b;
				m_len++;
			end else begin
				m_trunc = 1'b1;
			end
		end else if (b >= 8'h30 && b <= 8'h39) begin
			m_tag   = m_tag * 16'd10 + 16'(b - 8'h30);
			m_digit = 1'b1;
		end else begin
			m_err = 1'b1;
		end
	endtask

	// '|' in the text stands for SOH
	task automatic load_text(input string s);
		for (int i = 0; i < s.len(); i++) begin
			stream_q.push_back((s[i] == "|") ? `FIX_SOH : s[i]);
		end
	endtask

	// random fields until the stream fills whole words
	task automatic load_random(input int min_fields);
		int nfields;
		nfields = 0;
		while (nfields < min_fields || stream_q.size() % 4 != 0) begin
			repeat ($urandom_range(1, 3)) stream_q.push_back(8'h30 + 8'($urandom_range(0, 9)));
			stream_q.push_back(`FIX_SEP);
			repeat ($urandom_range(0, 10)) begin
				if ($urandom_range(0, 3) == 0) begin
					stream_q.push_back(`FIX_SEP);
				end else begin
					stream_q.push_back(8'h41 + 8'($urandom_range(0, 25)));
				end
			end
			stream_q.push_back(`FIX_SOH);
			nfields++;
		end
	endtask

	// holds the offered word until the DUT takes it
	task automatic wait_accept();
		int cycles;
		int start;
		cycles = 0;
		start  = words_in;
		while (words_in == start && cycles < WAIT_LIMIT) begin
			@(negedge clk_i);
			cycles++;
		end
		if (words_in == start) begin
			report_timeout("in_ready_o");
		end
	endtask

	task automatic wait_drained();
		int cycles;
		cycles = 0;
		while (exp_rd != exp_wr && cycles < WAIT_LIMIT) begin
			@(negedge clk_i);
			cycles++;
		end
		if (exp_rd != exp_wr) begin
			report_timeout("field_valid_o on the remaining expected fields");
		end
	endtask

	task automatic run_test(input string name);
		fix_pkg::word_t w;
		test_name = name;
		foreach (stream_q[i]) begin
			model_byte(stream_q[i]);
		end
		// lane 0 carries the first byte on the wire
		for (int i = 0; i + 3 < stream_q.size() && !timed_out; i += 4) begin
			w = {stream_q[i+3], stream_q[i+2], stream_q[i+1], stream_q[i]};
			if (rand_mode) begin
				in_valid_i = 1'b0;
				repeat ($urandom_range(0, 2)) @(negedge clk_i);
			end
			in_valid_i = 1'b1;
			in_data_i  = w;
			wait_accept();
		end
		in_valid_i = 1'b0;
		if (!timed_out) begin
			wait_drained();
		end
		stream_q.delete();
	endtask

	initial begin
		void'($urandom(69));
		arst_n_i     = 1'b0;
		in_valid_i   = 1'b0;
		in_data_i    = '0;
		rand_mode    = 1'b0;
		timed_out    = 1'b0;
		error_count  = 0;
		exp_wr       = '0;
		m_value_mode = 1'b0;
		m_tag        = '0;
		m_val        = '0;
		m_len        = 0;
		m_digit      = 1'b0;
		m_err        = 1'b0;
		m_trunc      = 1'b0;
		repeat (3) @(posedge clk_i);
		@(negedge clk_i);
		arst_n_i = 1'b1;

		load_text("35=A|49=ABC|");
		run_test("single");
		// tag 128 and its value both cross word edges
		load_text("10=77|128=ABCDE|");
		run_test("split");
		load_text("7=a=bc=d|1=|");
		run_test("multi");
		rand_mode = 1'b1;
		load_random(16);
		run_test("random");
		rand_mode = 1'b0;
		load_text("44=ABCDEFGHIJ|55=PQ|");
		run_test("trunc");
		load_text("3X=ab|=bc|17=ok|");
		run_test("err");

		$display("fields checked: %0d, errors: %0d", exp_rd, error_count);
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+.
fix_pkg.sv
fix_lane_classifier.sv
fix_word_fifo.sv
fix_field_assembler.sv
fix_field_extract.sv
tb_fix_field_extract.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_fix_field_extract
FLIST     = all.f
OBJ_DIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
